// ==== common/flip_pkg.sv ====
package flip_pkg;

    // spin vector geometry
    localparam int unsigned NUM_SPIN    = 16;
    localparam int unsigned PARALLELISM = 4;
    localparam int unsigned NUM_BLOCK   = NUM_SPIN / PARALLELISM;
    localparam int unsigned ADDR_WIDTH  = $clog2(NUM_BLOCK);

    // at least two baseline slots
    localparam int unsigned SPIN_DEPTH  = 2;
    localparam int unsigned IDX_WIDTH   = $clog2(SPIN_DEPTH);

    localparam int unsigned ENERGY_BITS = 16;

    typedef logic [NUM_SPIN-1:0] spin_t;

    // flip flags of one memory block
    typedef logic [PARALLELISM-1:0] block_bits_t;

    // one request bit per block
    typedef logic [NUM_BLOCK-1:0] block_mask_t;

    typedef logic [ADDR_WIDTH-1:0] raddr_t;

    typedef logic signed [ENERGY_BITS-1:0] energy_t;

    typedef logic [IDX_WIDTH-1:0] base_idx_t;

endpackage

// ==== common/flip_scan_if.sv ====
interface flip_scan_if;
    import flip_pkg::*;

    // request side carries the flip vector of the accepted spin
    logic   req_valid;
    spin_t  req_mask;
    raddr_t upper_bound;

    // grant side
    logic        idx_valid;
    raddr_t      idx;
    block_bits_t grant_bits;
    logic        idx_last;
    logic        idx_ready;

    modport filter (
        output req_valid,
        output req_mask,
        output upper_bound,
        output idx_ready,
        input  idx_valid,
        input  idx,
        input  grant_bits,
        input  idx_last
    );

    modport manager (
        input  req_valid,
        input  req_mask,
        input  upper_bound,
        input  idx_ready,
        output idx_valid,
        output idx,
        output grant_bits,
        output idx_last
    );

endinterface

// ==== flip_filter/raddr_manager.sv ====
module raddr_manager (
    input logic          clk_i,
    input logic          reset_i,
    input logic          flush_i,
    flip_scan_if.manager scan
);
    import flip_pkg::*;

    block_mask_t req_blocks;
    block_mask_t mask_q;
    block_mask_t bound_mask;
    block_mask_t avail;
    block_mask_t rest;
    spin_t       flip_q;
    raddr_t      grant_idx;
    logic        found;

    // one request per block holding any flipped spin
    always_comb begin
        for (int b = 0; b < NUM_BLOCK; b++) begin
            req_blocks[b] = |scan.req_mask[b*PARALLELISM +: PARALLELISM];
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BLOCK; b++) begin
            bound_mask[b] = (b <= int'(scan.upper_bound));
        end
    end

    assign avail = mask_q & bound_mask;

    // lowest index wins
    always_comb begin
        found     = 1'b0;
        grant_idx = '0;
        for (int b = NUM_BLOCK - 1; b >= 0; b--) begin
            if (avail[b]) begin
                found     = 1'b1;
                grant_idx = raddr_t'(b);
            end
        end
    end

    assign rest = avail & ~(block_mask_t'(1) << grant_idx);

    assign scan.idx_valid  = found;
    assign scan.idx        = grant_idx;
    assign scan.grant_bits = flip_q[grant_idx*PARALLELISM +: PARALLELISM];
    assign scan.idx_last   = found & ~(|rest);

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            mask_q <= '0;
        end else if (scan.req_valid) begin
            mask_q <= req_blocks;
        end else if (found && scan.idx_ready) begin
            mask_q[grant_idx] <= 1'b0;
        end
    end

    // copy of the flip vector for the block bits
    always_ff @(posedge clk_i) begin
        if (scan.req_valid) begin
            flip_q <= scan.req_mask;
        end
    end

endmodule

// ==== flip_filter/flip_filter.sv ====
module flip_filter (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                flush_i,
    input  flip_pkg::raddr_t    upper_bound_i,

    // baseline store
    input  flip_pkg::spin_t     sel_spin_i,
    input  flip_pkg::energy_t   sel_energy_i,
    output flip_pkg::base_idx_t sel_idx_o,

    // upstream
    input  logic                spin_valid_i,
    input  flip_pkg::spin_t     spin_i,
    output logic                spin_ready_o,

    // downstream
    output logic                spin_valid_o,
    output flip_pkg::spin_t     spin_o,
    input  logic                spin_ready_i,

    // coupling memory reads
    output logic                raddr_valid_o,
    output flip_pkg::raddr_t    raddr_o,
    output flip_pkg::block_bits_t block_bits_o,
    output logic                raddr_last_o,
    input  logic                raddr_ready_i,

    output logic                base_valid_o,
    output flip_pkg::energy_t   energy_base_o,
    output flip_pkg::spin_t     spin_base_o,
    output flip_pkg::spin_t     unflipped_o,

    flip_scan_if                scan
);
    import flip_pkg::*;

    logic      busy_q;
    logic      base_valid_q;
    base_idx_t sel_idx_q;
    spin_t     flip_live;
    spin_t     flip_q;
    logic      up_hs;
    logic      no_flip;
    logic      last_hs;
    logic      scan_done;

    assign up_hs   = spin_valid_i & spin_ready_o;

    // cold start reads every block
    assign flip_live = base_valid_q ? (spin_i ^ sel_spin_i) : {NUM_SPIN{1'b1}};
    assign no_flip   = ~(|flip_live);

    assign spin_ready_o = ~busy_q & spin_ready_i;
    assign spin_valid_o = up_hs & ~no_flip;
    assign spin_o       = spin_i;

    assign raddr_valid_o = busy_q & scan.idx_valid;
    assign raddr_o       = scan.idx;
    assign block_bits_o  = scan.grant_bits;
    assign raddr_last_o  = scan.idx_last;

    assign last_hs = raddr_valid_o & raddr_ready_i & scan.idx_last;

    // also ends a scan whose flips all lie above the bound
    assign scan_done = (up_hs & no_flip) | last_hs | (busy_q & ~scan.idx_valid);

    assign scan.req_valid   = up_hs & ~no_flip;
    assign scan.req_mask    = flip_live;
    assign scan.upper_bound = upper_bound_i;
    assign scan.idx_ready   = raddr_ready_i & busy_q;

    assign sel_idx_o     = sel_idx_q;
    assign base_valid_o  = base_valid_q;
    assign energy_base_o = sel_energy_i;
    assign spin_base_o   = sel_spin_i;
    assign unflipped_o   = up_hs ? ~flip_live : ~flip_q;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            busy_q <= 1'b0;
        end else if (scan.req_valid) begin
            busy_q <= 1'b1;
        end else if (scan_done) begin
            busy_q <= 1'b0;
        end
    end

    // slot rotation steps once per completed scan
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            sel_idx_q <= '0;
        end else if (scan_done) begin
            if (sel_idx_q == base_idx_t'(SPIN_DEPTH - 1)) begin
                sel_idx_q <= '0;
            end else begin
                sel_idx_q <= sel_idx_q + 1'b1;
            end
        end
    end

    // first wrap of the slot counter ends the cold start
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            base_valid_q <= 1'b0;
        end else if (scan_done && sel_idx_q == base_idx_t'(SPIN_DEPTH - 1)) begin
            base_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (up_hs) begin
            flip_q <= flip_live;
        end
    end

    raddr_manager u_raddr_manager (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .scan    (scan.manager)
    );

endmodule

// ==== source/baseline_store.sv ====
module baseline_store (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                we_i,
    input  flip_pkg::base_idx_t widx_i,
    input  flip_pkg::spin_t     spin_i,
    input  flip_pkg::energy_t   energy_i,
    input  flip_pkg::base_idx_t sel_idx_i,
    output flip_pkg::spin_t     sel_spin_o,
    output flip_pkg::energy_t   sel_energy_o
);
    import flip_pkg::*;

    spin_t   spin_q   [SPIN_DEPTH];
    energy_t energy_q [SPIN_DEPTH];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < SPIN_DEPTH; i++) begin
                spin_q[i]   <= '0;
                energy_q[i] <= '0;
            end
        end else if (we_i) begin
            spin_q[widx_i]   <= spin_i;
            energy_q[widx_i] <= energy_i;
        end
    end

    // combinational read of the selected slot
    assign sel_spin_o   = spin_q[sel_idx_i];
    assign sel_energy_o = energy_q[sel_idx_i];

endmodule

// ==== source/flip_scan_top.sv ====
module flip_scan_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  flip_pkg::raddr_t      upper_bound_i,

    // baseline writes
    input  logic                  base_we_i,
    input  flip_pkg::base_idx_t   base_widx_i,
    input  flip_pkg::spin_t       base_spin_i,
    input  flip_pkg::energy_t     base_energy_i,

    input  logic                  spin_valid_i,
    input  flip_pkg::spin_t       spin_i,
    output logic                  spin_ready_o,

    output logic                  spin_valid_o,
    output flip_pkg::spin_t       spin_o,
    input  logic                  spin_ready_i,

    output logic                  raddr_valid_o,
    output flip_pkg::raddr_t      raddr_o,
    output flip_pkg::block_bits_t block_bits_o,
    output logic                  raddr_last_o,
    input  logic                  raddr_ready_i,

    output logic                  base_valid_o,
    output flip_pkg::energy_t     energy_base_o,
    output flip_pkg::spin_t       spin_base_o,
    output flip_pkg::spin_t       unflipped_o
);
    import flip_pkg::*;

    base_idx_t sel_idx;
    spin_t     sel_spin;
    energy_t   sel_energy;

    flip_scan_if scan_bus ();

    baseline_store u_baseline_store (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .we_i         (base_we_i),
        .widx_i       (base_widx_i),
        .spin_i       (base_spin_i),
        .energy_i     (base_energy_i),
        .sel_idx_i    (sel_idx),
        .sel_spin_o   (sel_spin),
        .sel_energy_o (sel_energy)
    );

    flip_filter u_flip_filter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .upper_bound_i (upper_bound_i),
        .sel_spin_i    (sel_spin),
        .sel_energy_i  (sel_energy),
        .sel_idx_o     (sel_idx),
        .spin_valid_i  (spin_valid_i),
        .spin_i        (spin_i),
        .spin_ready_o  (spin_ready_o),
        .spin_valid_o  (spin_valid_o),
        .spin_o        (spin_o),
        .spin_ready_i  (spin_ready_i),
        .raddr_valid_o (raddr_valid_o),
        .raddr_o       (raddr_o),
        .block_bits_o  (block_bits_o),
        .raddr_last_o  (raddr_last_o),
        .raddr_ready_i (raddr_ready_i),
        .base_valid_o  (base_valid_o),
        .energy_base_o (energy_base_o),
        .spin_base_o   (spin_base_o),
        .unflipped_o   (unflipped_o),
        .scan          (scan_bus)
    );

endmodule

// ==== test/tb_flip_scan.sv ====
module tb_flip_scan;
    timeunit 1ns;
    timeprecision 1ps;
    import flip_pkg::*;

    localparam int ENTRIES     = 11;
    localparam int CYCLE_LIMIT = 40 * (ENTRIES + 1);

    logic        clk_i = 1'b0;
    logic        reset_i, flush_i, base_we_i;
    raddr_t      upper_bound_i, raddr_o;
    base_idx_t   base_widx_i;
    spin_t       base_spin_i, spin_i, spin_o, spin_base_o, unflipped_o;
    energy_t     base_energy_i, energy_base_o;
    logic        spin_valid_i, spin_ready_o, spin_valid_o, spin_ready_i;
    logic        raddr_valid_o, raddr_last_o, raddr_ready_i, base_valid_o;
    block_bits_t block_bits_o;

    // stimulus table
    string       t_name[$];
    spin_t       t_spin[$];
    logic        t_rdy[$], t_flush[$], t_valid[$];
    raddr_t      t_ub[$];
    block_mask_t t_mask[$];

    // reference state
    spin_t       base_spin [SPIN_DEPTH];
    energy_t     base_energy [SPIN_DEPTH];
    int          ref_sel = 0;
    int          ref_scans = 0;
    raddr_t      exp_addr[$];
    block_bits_t exp_bits[$];
    string       cur_name = "reset";
    int          cycle_cnt = 0;

    flip_scan_top DUT (.*);

    always #20 clk_i = ~clk_i;

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s (test %s)", msg, cur_name);
        stop_run();
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", cur_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_spin(input string what, input spin_t exp, input spin_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", cur_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string what, input raddr_t exp, input raddr_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bits(input string what, input block_bits_t exp, input block_bits_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", cur_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_energy(input string what, input energy_t exp, input energy_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic add_entry(input string name, input spin_t spin, input logic rdy,
                             input logic flush, input raddr_t ub, input logic valid,
                             input block_mask_t mask);
        t_name.push_back(name);
        t_spin.push_back(spin);
        t_rdy.push_back(rdy);
        t_flush.push_back(flush);
        t_ub.push_back(ub);
        t_valid.push_back(valid);
        t_mask.push_back(mask);
    endtask

    task automatic write_baseline(input int idx, input spin_t spin, input energy_t energy);
        @(negedge clk_i);
        base_we_i     = 1'b1;
        base_widx_i   = base_idx_t'(idx);
        base_spin_i   = spin;
        base_energy_i = energy;
        base_spin[idx]   = spin;
        base_energy[idx] = energy;
        @(negedge clk_i);
        base_we_i = 1'b0;
    endtask

    task automatic run_entry(input int e);
        spin_t flip;
        logic  cold;
        cur_name = t_name[e];
        @(negedge clk_i);
        upper_bound_i = t_ub[e];
        if (t_flush[e]) begin
            flush_i = 1'b1;
            @(negedge clk_i);
            flush_i   = 1'b0;
            ref_sel   = 0;
            ref_scans = 0;
        end
        // all spins count as flipped until every slot was used once
        cold = (ref_scans < SPIN_DEPTH);
        flip = cold ? '1 : (t_spin[e] ^ base_spin[ref_sel]);
        for (int b = 0; b < NUM_BLOCK; b++) begin
            if (t_mask[e][b]) begin
                exp_addr.push_back(raddr_t'(b));
                exp_bits.push_back(flip[b*PARALLELISM +: PARALLELISM]);
            end
        end
        spin_i       = t_spin[e];
        spin_valid_i = 1'b1;
        spin_ready_i = t_rdy[e];
        if (!t_rdy[e]) begin
            repeat (3) begin
                #15;
                check_flag("spin_ready_o under stall", 1'b0, spin_ready_o);
                check_flag("spin_valid_o under stall", 1'b0, spin_valid_o);
                @(negedge clk_i);
            end
            spin_ready_i = 1'b1;
        end
        #15;
        check_flag("spin_ready_o", 1'b1, spin_ready_o);
        check_flag("spin_valid_o", t_valid[e], spin_valid_o);
        check_spin("spin_o", t_spin[e], spin_o);
        check_spin("spin_base_o", base_spin[ref_sel], spin_base_o);
        check_energy("energy_base_o", base_energy[ref_sel], energy_base_o);
        check_flag("base_valid_o", ~cold, base_valid_o);
        check_spin("unflipped_o", ~flip, unflipped_o);
        @(negedge clk_i);
        spin_valid_i = 1'b0;
        #15;
        // held copy of the accepted flip vector
        check_spin("unflipped_o after accept", ~flip, unflipped_o);
        while (!(spin_ready_o && exp_addr.size() == 0)) begin
            if (spin_ready_o) begin
                report_failure("scan ended while expected read addresses were still missing");
            end
            @(negedge clk_i);
            #15;
        end
        ref_sel = (ref_sel + 1) % SPIN_DEPTH;
        if (ref_scans < SPIN_DEPTH) begin
            ref_scans++;
        end
    endtask

    // memory side with random stalls on the read addresses
    initial begin : mem_responder
        logic        held;
        raddr_t      held_addr;
        block_bits_t held_bits;
        void'($urandom(8));
        held          = 1'b0;
        held_addr     = '0;
        held_bits     = '0;
        raddr_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            raddr_ready_i = $urandom % 2;
            #10;
            if (held) begin
                check_flag("raddr_valid_o while stalled", 1'b1, raddr_valid_o);
                check_addr("raddr_o while stalled", held_addr, raddr_o);
                check_bits("block_bits_o while stalled", held_bits, block_bits_o);
            end
            held = 1'b0;
            if (raddr_valid_o === 1'b1) begin
                if (raddr_ready_i) begin
                    if (exp_addr.size() == 0) begin
                        report_failure("read address issued although none was expected");
                    end
                    check_addr("raddr_o", exp_addr[0], raddr_o);
                    check_bits("block_bits_o", exp_bits[0], block_bits_o);
                    check_flag("raddr_last_o", exp_addr.size() == 1, raddr_last_o);
                    void'(exp_addr.pop_front());
                    void'(exp_bits.pop_front());
                end else begin
                    held      = 1'b1;
                    held_addr = raddr_o;
                    held_bits = block_bits_o;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            report_failure($sformatf("timeout, run still going after %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        upper_bound_i = raddr_t'(3);
        base_we_i     = 1'b0;
        base_widx_i   = '0;
        base_spin_i   = '0;
        base_energy_i = '0;
        spin_valid_i  = 1'b0;
        spin_i        = '0;
        spin_ready_i  = 1'b1;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        write_baseline(0, 16'hA5A5, 16'sd120);
        write_baseline(1, 16'h3C3C, -16'sd75);

        // name, spin, spin_ready_i, flush, bound, downstream, blocks read
        add_entry("cold0",       16'h1234, 1'b1, 1'b0, 2'd3, 1'b1, 4'b1111);
        add_entry("cold1",       16'h5678, 1'b1, 1'b0, 2'd3, 1'b1, 4'b1111);
        add_entry("diff_b0",     16'hA6A4, 1'b1, 1'b0, 2'd3, 1'b1, 4'b0101);
        add_entry("same_b1",     16'h3C3C, 1'b1, 1'b0, 2'd3, 1'b0, 4'b0000);
        add_entry("next_b0",     16'h55A5, 1'b1, 1'b0, 2'd3, 1'b1, 4'b1000);
        add_entry("stall_up",    16'h3CCC, 1'b0, 1'b0, 2'd3, 1'b1, 4'b0010);
        add_entry("bound1",      16'hB4B4, 1'b1, 1'b0, 2'd1, 1'b1, 4'b0011);
        add_entry("bound_hi",    16'hCC3C, 1'b1, 1'b0, 2'd1, 1'b1, 4'b0000);
        add_entry("flush_cold",  16'h0000, 1'b1, 1'b1, 2'd3, 1'b1, 4'b1111);
        add_entry("cold_again",  16'hFFFF, 1'b1, 1'b0, 2'd3, 1'b1, 4'b1111);
        add_entry("post_flush",  16'hA5B5, 1'b1, 1'b0, 2'd3, 1'b1, 4'b0010);

        for (int e = 0; e < ENTRIES; e++) begin
            run_entry(e);
        end
        cur_name = "final";
        check_flag("base_valid_o", 1'b1, base_valid_o);

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== project.f ====
common/flip_pkg.sv
common/flip_scan_if.sv
flip_filter/raddr_manager.sv
flip_filter/flip_filter.sv
source/baseline_store.sv
source/flip_scan_top.sv
test/tb_flip_scan.sv

// ==== Bender.yml ====
package:
  name: flip_scan

sources:
  - common/flip_pkg.sv
  - common/flip_scan_if.sv
  - flip_filter/raddr_manager.sv
  - flip_filter/flip_filter.sv
  - source/baseline_store.sv
  - source/flip_scan_top.sv
  - target: test
    files:
      - test/tb_flip_scan.sv
